// File: hw/dma_params.svh
//----------------------------------------
// Channel count, command register fields and reset
// values, shared by the DMA request and priority logic
//----------------------------------------
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

`define DMA_CHANNELS 4

// command register bit positions
`define DMA_CMD_DISABLE 2
`define DMA_CMD_ROTATE 4
`define DMA_CMD_DREQ_LOW 6
`define DMA_CMD_DACK_LOW 7

// set/clear bit in request and single mask writes
`define DMA_WR_SET_BIT 2

`define DMA_CMD_RESET 8'h00
`define DMA_MASK_RESET {`DMA_CHANNELS{1'b1}}
`define DMA_REQ_RESET {`DMA_CHANNELS{1'b0}}

`endif

// File: hw/dma_pkg.sv
//----------------------------------------
// Types shared by the DMA request and priority section.
// Imported by the stages, the register file and the top
//----------------------------------------
`include "dma_params.svh"

package dma_pkg;

	// one bit per channel
	typedef logic [`DMA_CHANNELS-1:0] chanVecT;

	// channel number
	typedef logic [$clog2(`DMA_CHANNELS)-1:0] chanIdT;

	// host register select
	typedef enum logic [1:0] {
		REG_COMMAND     = 2'd0,
		REG_REQUEST     = 2'd1,
		REG_SINGLE_MASK = 2'd2,
		REG_ALL_MASK    = 2'd3
	} regSelE;

	// bus hold and acknowledge sequence
	typedef enum logic [1:0] {
		ACK_IDLE     = 2'd0,
		ACK_HOLD_REQ = 2'd1,
		ACK_SERVICE  = 2'd2
	} ackStateE;

endpackage

// File: hw/DmaStageIf.sv
//----------------------------------------
// Links between request, priority and acknowledge stages.
// One instance in the top, one modport per consumer
//----------------------------------------
`timescale 1ns/1ps

interface DmaStageIf import dma_pkg::*; ();

	// conditioned requests
	chanVecT validReq;

	// one-cycle grant pulse
	logic grantValid;
	chanIdT grantCh;

	// service status
	logic ackBusy;
	logic doneValid;
	chanIdT doneCh;

	modport REQ (
		output validReq
	);

	modport PRIO (
		input validReq, ackBusy, doneValid,
		output grantValid, grantCh
	);

	modport ACK (
		input grantValid, grantCh,
		output ackBusy, doneValid, doneCh
	);

	modport REGS (
		input doneValid, doneCh
	);

endinterface

// File: hw/DmaRegFile.sv
//----------------------------------------
// Host writable command, mask and request registers.
// Software request of a channel drops when its service ends
//----------------------------------------
`timescale 1ns/1ps

`include "dma_params.svh"

module DmaRegFile import dma_pkg::*; (
	input logic dma_if,
	input logic rst,
	input logic wr,
	input regSelE regSel,
	input logic [7:0] wrData,
	output logic [7:0] commandReg,
	output chanVecT maskReg,
	output chanVecT requestReg,
	DmaStageIf.REGS sif
);

	chanIdT wrCh;
	logic wrSet;

	// channel and set/clear fields of single bit writes
	assign wrCh = chanIdT'(wrData);
	assign wrSet = wrData[`DMA_WR_SET_BIT];

	//----------------------------------------
	// command register
	//----------------------------------------
	always_ff @(posedge dma_if) begin
		if (rst) begin
			commandReg <= `DMA_CMD_RESET;
		end else if (wr && regSel == REG_COMMAND) begin
			commandReg <= wrData;
		end
	end

	//----------------------------------------
	// mask register
	//----------------------------------------
	always_ff @(posedge dma_if) begin
		if (rst) begin
			maskReg <= `DMA_MASK_RESET;
		end else if (wr) begin
			case (regSel)
				REG_SINGLE_MASK: maskReg[wrCh] <= wrSet;
				REG_ALL_MASK: maskReg <= wrData[`DMA_CHANNELS-1:0];
				default: maskReg <= maskReg;
			endcase
		end
	end

	//----------------------------------------
	// software request register
	//----------------------------------------
	always_ff @(posedge dma_if) begin
		if (rst) begin
			requestReg <= `DMA_REQ_RESET;
		end else begin
			// end of service clears the served channel
			if (sif.doneValid) begin
				requestReg[sif.doneCh] <= 1'b0;
			end
			// a host write in the same cycle wins
			if (wr && regSel == REG_REQUEST) begin
				requestReg[wrCh] <= wrSet;
			end
		end
	end

endmodule

// File: hw/DmaRequestStage.sv
//----------------------------------------
// Request conditioning: DREQ polarity, software requests
// and channel masks, registered once toward the arbiter
//----------------------------------------
`timescale 1ns/1ps

module DmaRequestStage import dma_pkg::*; (
	input logic dma_if,
	input logic rst,
	input chanVecT dreq,
	input logic dreqLow,
	input chanVecT maskReg,
	input chanVecT requestReg,
	DmaStageIf.REQ sif
);

	chanVecT dreqActive;
	chanVecT reqMerged;
	chanVecT reqNext;

	// active high view of the DREQ pins
	always_comb begin
		if (dreqLow) begin
			dreqActive = ~dreq;
		end else begin
			dreqActive = dreq;
		end
	end

	// hardware or software request, then the mask
	always_comb begin
		reqMerged = dreqActive | requestReg;
		reqNext = reqMerged & ~maskReg;
	end

	//----------------------------------------
	// stage register
	//----------------------------------------
	always_ff @(posedge dma_if) begin
		if (rst) begin
			sif.validReq <= '0;
		end else begin
			sif.validReq <= reqNext;
		end
	end

endmodule

// File: hw/DmaPriority.sv
//----------------------------------------
// Fixed or rotating priority arbiter with rotation pointer.
// Issues a one-cycle grant while the acknowledge stage is free
//----------------------------------------
`timescale 1ns/1ps

`include "dma_params.svh"

module DmaPriority import dma_pkg::*; (
	input logic dma_if,
	input logic rst,
	input logic rotate,
	input logic dmaDisable,
	DmaStageIf.PRIO sif
);

	chanIdT rotPtr;
	chanIdT searchBase;
	chanIdT winCh;
	logic winFound;
	logic doneHold;
	logic canGrant;

	// fixed mode always starts at channel 0
	assign searchBase = rotate ? rotPtr : '0;

	//----------------------------------------
	// search upward from the base, wrapping
	//----------------------------------------
	always_comb begin
		chanIdT idx;
		winFound = 1'b0;
		winCh = searchBase;
		for (int i = 0; i < `DMA_CHANNELS; i++) begin
			idx = chanIdT'(searchBase + i);
			if (!winFound && sif.validReq[idx]) begin
				winFound = 1'b1;
				winCh = idx;
			end
		end
	end

	// requests stay stale for two cycles after a service ends,
	// until the cleared software bit passes the request stage
	always_ff @(posedge dma_if) begin
		if (rst) begin
			doneHold <= 1'b0;
		end else begin
			doneHold <= sif.doneValid;
		end
	end

	// one grant at a time, never into a busy acknowledge stage
	assign canGrant = winFound && !dmaDisable && !sif.ackBusy && !sif.grantValid
		&& !sif.doneValid && !doneHold;

	//----------------------------------------
	// grant pulse and rotation pointer
	//----------------------------------------
	always_ff @(posedge dma_if) begin
		if (rst) begin
			sif.grantValid <= 1'b0;
			rotPtr <= '0;
		end else begin
			sif.grantValid <= canGrant;
			if (canGrant) begin
				// granted channel drops to lowest priority
				rotPtr <= winCh + 1'b1;
			end
		end
	end

	// payload, qualified by grantValid
	always_ff @(posedge dma_if) begin
		if (canGrant) begin
			sif.grantCh <= winCh;
		end
	end

endmodule

// File: hw/DmaAckStage.sv
//----------------------------------------
// Bus hold sequence: HRQ, wait for HLDA, drive DACK
// with programmable polarity until EOP ends the service
//----------------------------------------
`timescale 1ns/1ps

module DmaAckStage import dma_pkg::*; (
	input logic dma_if,
	input logic rst,
	input logic dackLow,
	input logic hlda,
	input logic eop,
	output logic hrq,
	output chanVecT dack,
	DmaStageIf.ACK sif
);

	ackStateE state;
	chanIdT heldCh;
	chanVecT dackAct;

	//----------------------------------------
	// FSM
	//----------------------------------------
	always_ff @(posedge dma_if) begin
		if (rst) begin
			state <= ACK_IDLE;
			dackAct <= '0;
			sif.doneValid <= 1'b0;
		end else begin
			sif.doneValid <= 1'b0;
			case (state)
				ACK_IDLE: begin
					if (sif.grantValid) begin
						state <= ACK_HOLD_REQ;
					end
				end
				ACK_HOLD_REQ: begin
					// bus granted by the CPU
					if (hlda) begin
						state <= ACK_SERVICE;
						dackAct <= chanVecT'(1) << heldCh;
					end
				end
				ACK_SERVICE: begin
					if (eop) begin
						state <= ACK_IDLE;
						dackAct <= '0;
						sif.doneValid <= 1'b1;
					end
				end
				default: begin
					state <= ACK_IDLE;
					dackAct <= '0;
				end
			endcase
		end
	end

	// channel under service, loaded with the grant
	always_ff @(posedge dma_if) begin
		if (state == ACK_IDLE && sif.grantValid) begin
			heldCh <= sif.grantCh;
		end
	end

	assign hrq = (state != ACK_IDLE);
	assign sif.ackBusy = (state != ACK_IDLE);
	assign sif.doneCh = heldCh;

	// inactive channels follow the programmed idle level
	assign dack = dackLow ? ~dackAct : dackAct;

endmodule

// File: hw/DmaTop.sv
//----------------------------------------
// DMA request and priority section, four channels.
// Host register writes, DREQ in, HRQ/HLDA and DACK out
//----------------------------------------
`timescale 1ns/1ps

`include "dma_params.svh"

module DmaTop import dma_pkg::*; (
	input logic dma_if,
	input logic rst,
	input chanVecT dreq,
	input logic hlda,
	input logic eop,
	input logic wr,
	input regSelE regSel,
	input logic [7:0] wrData,
	output logic hrq,
	output chanVecT dack
);

	logic [7:0] commandReg;
	chanVecT maskReg;
	chanVecT requestReg;
	logic dreqLow;
	logic rotate;
	logic dmaDisable;
	logic dackLow;

	// command register fields
	assign dreqLow = commandReg[`DMA_CMD_DREQ_LOW];
	assign rotate = commandReg[`DMA_CMD_ROTATE];
	assign dmaDisable = commandReg[`DMA_CMD_DISABLE];
	assign dackLow = commandReg[`DMA_CMD_DACK_LOW];

	DmaStageIf stageIf ();

	DmaRegFile regFile (
		.dma_if(dma_if), .rst(rst), .wr(wr), .regSel(regSel), .wrData(wrData),
		.commandReg(commandReg), .maskReg(maskReg), .requestReg(requestReg),
		.sif(stageIf)
	);

	DmaRequestStage reqStage (
		.dma_if(dma_if), .rst(rst), .dreq(dreq), .dreqLow(dreqLow),
		.maskReg(maskReg), .requestReg(requestReg), .sif(stageIf)
	);

	DmaPriority prio (
		.dma_if(dma_if), .rst(rst), .rotate(rotate), .dmaDisable(dmaDisable),
		.sif(stageIf)
	);

	DmaAckStage ackStage (
		.dma_if(dma_if), .rst(rst), .dackLow(dackLow), .hlda(hlda), .eop(eop),
		.hrq(hrq), .dack(dack), .sif(stageIf)
	);

endmodule

// File: verif/DmaClockGen.sv
//----------------------------------------
// Testbench clock, 20 ns period, and a
// synchronous reset held for 8 cycles
//----------------------------------------
`timescale 1ns/1ps

module DmaClockGen (
	output logic dma_if,
	output logic rst
);

	initial begin
		dma_if = 1'b0;
		forever #10 dma_if = ~dma_if;
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge dma_if);
		#2 rst = 1'b0;
	end

endmodule

// File: verif/DmaTop_assert.sv
//----------------------------------------
// Protocol rules of the acknowledge side,
// bound to every DmaTop instance
//----------------------------------------
`timescale 1ns/1ps

`include "dma_params.svh"

module DmaTop_assert import dma_pkg::*; (
	input logic dma_if,
	input logic rst,
	input logic hrq,
	input logic hlda,
	input logic dackLow,
	input logic grantValid,
	input chanVecT dack
);

	chanVecT dackIdle;

	// inactive level follows the command register
	assign dackIdle = {`DMA_CHANNELS{dackLow}};

	oneDack: assert property (@(posedge dma_if) disable iff (rst)
		$onehot0(dack ^ dackIdle))
		else $error("more than one dack line active");

	hrqAfterGrant: assert property (@(posedge dma_if) disable iff (rst)
		$rose(hrq) |-> $past(grantValid))
		else $error("hrq rose without a grant");

	dackNeedsHlda: assert property (@(posedge dma_if) disable iff (rst)
		(dack != dackIdle) |-> hlda)
		else $error("dack active while hlda low");

endmodule

bind DmaTop DmaTop_assert topAssert (
	.dma_if(dma_if), .rst(rst), .hrq(hrq), .hlda(hlda), .dackLow(dackLow),
	.grantValid(stageIf.grantValid), .dack(dack)
);

// File: verif/DmaTb.sv
//----------------------------------------
// Directed tests of the DMA request and priority section.
// Each test is a task and the results are summed at the end
//----------------------------------------
`timescale 1ns/1ps

`include "dma_params.svh"

module DmaTb import dma_pkg::*; ();

	logic dma_if;
	logic rst;
	logic hlda;
	logic eop;
	logic wr;
	logic hrq;
	chanVecT dreq;
	chanVecT dack;
	regSelE regSel;
	logic [7:0] wrData;

	int errorCount;
	int testCount;
	int testErrors;
	string testName;
	logic tbDackLow;
	chanIdT ptrModel;

	DmaClockGen clockGen (.dma_if(dma_if), .rst(rst));

	DmaTop UUT (
		.dma_if(dma_if), .rst(rst), .dreq(dreq), .hlda(hlda), .eop(eop), .wr(wr),
		.regSel(regSel), .wrData(wrData), .hrq(hrq), .dack(dack)
	);

	//----------------------------------------
	// helpers
	//----------------------------------------
	// inputs change 2 ns after the rising edge
	task automatic stepCycle(int n = 1);
		repeat (n) begin
			@(posedge dma_if);
			#2;
		end
	endtask

	task automatic checkChan(string what, chanIdT expVal, chanIdT actVal);
		if (expVal !== actVal) begin
			errorCount++;
			$display("FAIL %s: %s expected %0d actual %0d", testName, what, expVal, actVal);
		end
	endtask

	task automatic checkVec(string what, chanVecT expVal, chanVecT actVal);
		if (expVal !== actVal) begin
			errorCount++;
			$display("FAIL %s: %s expected %b actual %b", testName, what, expVal, actVal);
		end
	endtask

	task automatic reportError(string msg);
		errorCount++;
		$display("ERROR %s: %s", testName, msg);
	endtask

	task automatic startTest(string name);
		testName = name;
		testErrors = errorCount;
		testCount++;
	endtask

	task automatic endTest();
		$display("%s: %s", testName, (errorCount == testErrors) ? "passed" : "failed");
	endtask

	task automatic writeReg(regSelE sel, logic [7:0] data);
		regSel = sel;
		wrData = data;
		wr = 1'b1;
		stepCycle();
		wr = 1'b0;
	endtask

	// first requester at or above base with wraparound
	function automatic chanIdT pickChannel(chanVecT req, chanIdT base);
		chanIdT idx;
		pickChannel = base;
		for (int i = `DMA_CHANNELS - 1; i >= 0; i--) begin
			idx = chanIdT'(base + i);
			if (req[idx]) begin
				pickChannel = idx;
			end
		end
	endfunction

	function automatic chanVecT idleDack();
		return {`DMA_CHANNELS{tbDackLow}};
	endfunction

	task automatic waitHrq(output logic ok);
		ok = hrq;
		for (int i = 0; i < 40 && !ok; i++) begin
			stepCycle();
			ok = hrq;
		end
	endtask

	// one full bus hold that returns the acknowledged channel
	task automatic serviceChannel(output chanIdT ch, output chanVecT seen, output logic ok);
		logic gotDack;
		ch = '0;
		seen = idleDack();
		gotDack = 1'b0;
		waitHrq(ok);
		if (!ok) begin
			reportError("timeout waiting for hrq");
			return;
		end
		hlda = 1'b1;
		for (int i = 0; i < 20 && !gotDack; i++) begin
			stepCycle();
			gotDack = (dack != idleDack());
		end
		if (gotDack) begin
			seen = dack;
			for (int i = 0; i < `DMA_CHANNELS; i++) begin
				if (dack[i] != tbDackLow) begin
					ch = chanIdT'(i);
				end
			end
			eop = 1'b1;
			stepCycle();
			eop = 1'b0;
		end else begin
			reportError("timeout waiting for dack after hlda");
			ok = 1'b0;
		end
		hlda = 1'b0;
	endtask

	//----------------------------------------
	// tests
	//----------------------------------------
	task automatic testResetMask();
		chanIdT ch;
		chanVecT seen;
		logic ok;
		startTest("reset and mask");
		dreq = '1;
		stepCycle(6);
		if (hrq) begin
			reportError("hrq raised while all channels were masked");
		end
		// unmask channel 2 only
		writeReg(REG_SINGLE_MASK, 8'h02);
		serviceChannel(ch, seen, ok);
		dreq = '0;
		if (ok) begin
			checkChan("served channel", 2'd2, ch);
		end
		writeReg(REG_ALL_MASK, 8'h00);
		stepCycle(2);
		endTest();
	endtask

	task automatic testFixedPriority();
		chanIdT ch;
		chanIdT expCh;
		chanVecT seen;
		chanVecT pat;
		logic ok;
		startTest("fixed priority");
		for (int n = 0; n < 8; n++) begin
			pat = chanVecT'($urandom);
			if (pat == '0) begin
				pat = 4'b1010;
			end
			expCh = pickChannel(pat, '0);
			dreq = pat;
			serviceChannel(ch, seen, ok);
			dreq = '0;
			if (ok) begin
				checkChan("lowest requester", expCh, ch);
			end
			stepCycle(2);
		end
		endTest();
	endtask

	task automatic testRotatePriority();
		chanIdT ch;
		chanIdT expCh;
		chanVecT seen;
		chanVecT pat;
		logic ok;
		startTest("rotating priority");
		// serving channel 3 moves the pointer to 0
		dreq = 4'b1000;
		serviceChannel(ch, seen, ok);
		dreq = '0;
		if (ok) begin
			checkChan("setup channel", 2'd3, ch);
		end
		ptrModel = '0;
		stepCycle(2);
		writeReg(REG_COMMAND, 8'h1 << `DMA_CMD_ROTATE);
		dreq = '1;
		for (int i = 0; i < 5; i++) begin
			serviceChannel(ch, seen, ok);
			if (ok) begin
				checkChan("rotation order", chanIdT'(i), ch);
			end
			ptrModel = chanIdT'(i + 1);
		end
		dreq = '0;
		stepCycle(3);
		for (int n = 0; n < 8; n++) begin
			pat = chanVecT'($urandom);
			if (pat == '0) begin
				pat = 4'b0110;
			end
			expCh = pickChannel(pat, ptrModel);
			dreq = pat;
			serviceChannel(ch, seen, ok);
			dreq = '0;
			if (ok) begin
				checkChan("pointer winner", expCh, ch);
			end
			// pointer moves past the expected winner
			ptrModel = expCh + 1'b1;
			stepCycle(2);
		end
		writeReg(REG_COMMAND, 8'h00);
		endTest();
	endtask

	task automatic testPolarity();
		chanIdT ch;
		chanVecT seen;
		logic ok;
		startTest("polarity");
		writeReg(REG_ALL_MASK, 8'h0F);
		dreq = '1;
		writeReg(REG_COMMAND, (8'h1 << `DMA_CMD_DREQ_LOW) | (8'h1 << `DMA_CMD_DACK_LOW));
		tbDackLow = 1'b1;
		writeReg(REG_ALL_MASK, 8'h00);
		stepCycle(6);
		if (hrq) begin
			reportError("hrq raised with every dreq line high");
		end
		checkVec("idle dack", 4'b1111, dack);
		// channel 1 pulls its line low
		dreq = 4'b1101;
		serviceChannel(ch, seen, ok);
		dreq = '1;
		if (ok) begin
			checkChan("served channel", 2'd1, ch);
			checkVec("served dack", 4'b1101, seen);
		end
		writeReg(REG_ALL_MASK, 8'h0F);
		dreq = '0;
		writeReg(REG_COMMAND, 8'h00);
		tbDackLow = 1'b0;
		writeReg(REG_ALL_MASK, 8'h00);
		stepCycle(2);
		endTest();
	endtask

	task automatic testSoftwareRequest();
		chanIdT ch;
		chanVecT seen;
		logic ok;
		startTest("software request");
		dreq = '0;
		// set request of channel 3
		writeReg(REG_REQUEST, 8'h07);
		serviceChannel(ch, seen, ok);
		if (ok) begin
			checkChan("served channel", 2'd3, ch);
		end
		stepCycle(8);
		if (hrq) begin
			reportError("hrq returned after the software request was served");
		end
		endTest();
	endtask

	task automatic testDisableHold();
		chanIdT ch;
		chanVecT seen;
		logic ok;
		startTest("disable and back-pressure");
		writeReg(REG_COMMAND, 8'h1 << `DMA_CMD_DISABLE);
		dreq = 4'b0001;
		stepCycle(8);
		if (hrq) begin
			reportError("hrq raised while the controller was disabled");
		end
		dreq = '0;
		writeReg(REG_COMMAND, 8'h00);
		stepCycle(2);
		dreq = 4'b0010;
		waitHrq(ok);
		if (!ok) begin
			reportError("timeout waiting for hrq");
		end
		// hlda held low
		for (int i = 0; i < 10; i++) begin
			stepCycle();
			if (!hrq) begin
				reportError("hrq dropped before hlda arrived");
			end
			checkVec("dack before hlda", idleDack(), dack);
		end
		serviceChannel(ch, seen, ok);
		dreq = '0;
		if (ok) begin
			checkChan("held channel", 2'd1, ch);
		end
		stepCycle(2);
		endTest();
	endtask

	//----------------------------------------
	// main sequence
	//----------------------------------------
	initial begin
		logic resetDone;
		dreq = '0;
		hlda = 1'b0;
		eop = 1'b0;
		wr = 1'b0;
		regSel = REG_COMMAND;
		wrData = '0;
		errorCount = 0;
		testCount = 0;
		tbDackLow = 1'b0;
		ptrModel = '0;
		void'($urandom(31695));
		resetDone = 1'b0;
		for (int i = 0; i < 20 && !resetDone; i++) begin
			stepCycle();
			resetDone = !rst;
		end
		if (resetDone) begin
			testResetMask();
			testFixedPriority();
			testRotatePriority();
			testPolarity();
			testSoftwareRequest();
			testDisableHold();
		end else begin
			errorCount++;
			$display("reset was never released");
		end
		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/dma_pkg.sv
hw/DmaStageIf.sv
hw/DmaRegFile.sv
hw/DmaRequestStage.sv
hw/DmaPriority.sv
hw/DmaAckStage.sv
hw/DmaTop.sv
verif/DmaClockGen.sv
verif/DmaTop_assert.sv
verif/DmaTb.sv
